// File: axi_bridge_1x1.f
verilog/axi_bridge_pkg.sv
verilog/axi_write_path.sv
verilog/axi_read_path.sv
verilog/axi_decerr_target.sv
verilog/axi_bridge_1x1.sv
testbench/tb_mem_slave.sv
testbench/tb_axi_bridge_1x1.sv

// File: run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f axi_bridge_1x1.f \
	--top-module tb_axi_bridge_1x1 \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: testbench/tb_axi_bridge_1x1.sv
//==============================
// Testbench for the AXI4 bridge
// Clock, reset, directed tests,
// compare tasks and timeout
//==============================
`default_nettype none
`timescale 1ns/100ps

module tb_axi_bridge_1x1
	import axi_bridge_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [ADDR_W-1:0] KEEP_ADDR = 32'h0000_1400;
	// Lands on the same memory word as KEEP_ADDR if it were misrouted
	localparam logic [ADDR_W-1:0] BAD_ADDR = 32'h0000_2000;

	logic clk;
	logic rstn;
	ax_req_t m_aw;
	logic m_awvalid;
	logic m_awready;
	w_beat_t m_w;
	logic m_wvalid;
	logic m_wready;
	b_resp_t m_b;
	logic m_bvalid;
	logic m_bready;
	ax_req_t m_ar;
	logic m_arvalid;
	logic m_arready;
	r_beat_t m_r;
	logic m_rvalid;
	logic m_rready;
	ax_req_t s_aw;
	logic s_awvalid;
	logic s_awready;
	w_beat_t s_w;
	logic s_wvalid;
	logic s_wready;
	b_resp_t s_b;
	logic s_bvalid;
	logic s_bready;
	ax_req_t s_ar;
	logic s_arvalid;
	logic s_arready;
	r_beat_t s_r;
	logic s_rvalid;
	logic s_rready;

	int errors;
	int checks;
	int cycles;
	logic [DATA_W-1:0] wbuf [0:15];
	r_beat_t rbuf [0:15];
	logic [4:0] rcount;
	logic [DATA_W-1:0] keep_data;

	axi_bridge_1x1 #(
		.SLAVE0_BASE(32'h0000_1000),
		.SLAVE0_LIMIT(32'h0000_1FFF)
	) u_axi_bridge_1x1 (
		.clk(clk), .rstn(rstn),
		.m_aw_i(m_aw), .m_awvalid_i(m_awvalid), .m_awready_o(m_awready),
		.m_w_i(m_w), .m_wvalid_i(m_wvalid), .m_wready_o(m_wready),
		.m_b_o(m_b), .m_bvalid_o(m_bvalid), .m_bready_i(m_bready),
		.m_ar_i(m_ar), .m_arvalid_i(m_arvalid), .m_arready_o(m_arready),
		.m_r_o(m_r), .m_rvalid_o(m_rvalid), .m_rready_i(m_rready),
		.s_aw_o(s_aw), .s_awvalid_o(s_awvalid), .s_awready_i(s_awready),
		.s_w_o(s_w), .s_wvalid_o(s_wvalid), .s_wready_i(s_wready),
		.s_b_i(s_b), .s_bvalid_i(s_bvalid), .s_bready_o(s_bready),
		.s_ar_o(s_ar), .s_arvalid_o(s_arvalid), .s_arready_i(s_arready),
		.s_r_i(s_r), .s_rvalid_i(s_rvalid), .s_rready_o(s_rready)
	);

	tb_mem_slave u_mem (
		.clk(clk), .rstn(rstn),
		.aw_i(s_aw), .awvalid_i(s_awvalid), .awready_o(s_awready),
		.w_i(s_w), .wvalid_i(s_wvalid), .wready_o(s_wready),
		.b_o(s_b), .bvalid_o(s_bvalid), .bready_i(s_bready),
		.ar_i(s_ar), .arvalid_i(s_arvalid), .arready_o(s_arready),
		.r_o(s_r), .rvalid_o(s_rvalid), .rready_i(s_rready)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped, no end of tests within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic ax_req_t make_req(input logic [ADDR_W-1:0] addr,
		input logic [ID_W-1:0] id, input logic [7:0] len);
		ax_req_t req;
		req = '0;
		req.addr = addr;
		req.id = id;
		req.len = len;
		req.size = 3'd2;
		req.burst = 2'b01;
		return req;
	endfunction

	function automatic b_resp_t exp_b(input logic [ID_W-1:0] id, input resp_e resp);
		b_resp_t b;
		b.id = id;
		b.resp = resp;
		return b;
	endfunction

	function automatic r_beat_t exp_r(input logic [ID_W-1:0] id,
		input logic [DATA_W-1:0] data, input resp_e resp, input logic last);
		r_beat_t r;
		r.id = id;
		r.data = data;
		r.resp = resp;
		r.last = last;
		return r;
	endfunction

	task automatic compare_b(input b_resp_t got, input b_resp_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t ns: %s B id %0h resp %0d, expected id %0h resp %0d",
				$time, what, got.id, got.resp, exp.id, exp.resp);
		end
	endtask

	task automatic compare_r(input r_beat_t got, input r_beat_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t ns: %s R id %0h data %h resp %0d last %0b", $time, what,
				got.id, got.data, got.resp, got.last);
			$display("  expected id %0h data %h resp %0d last %0b",
				exp.id, exp.data, exp.resp, exp.last);
		end
	endtask

	task automatic compare_ready(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input logic [4:0] got, input logic [4:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t ns: %s gave %0d beats, expected %0d", $time, what, got, exp);
		end
	endtask

	// Starts and ends 10 ns after a rising edge
	task automatic write_burst(input ax_req_t req, output b_resp_t b);
		logic [7:0] beat;
		m_aw = req;
		m_awvalid = 1'b1;
		@(negedge clk);
		while (!m_awready) @(negedge clk);
		@(posedge clk);
		#10;
		m_awvalid = 1'b0;
		beat = 8'd0;
		do begin
			m_w.data = wbuf[beat[3:0]];
			m_w.strb = '1;
			m_w.last = (beat == req.len);
			m_wvalid = 1'b1;
			@(negedge clk);
			while (!m_wready) @(negedge clk);
			@(posedge clk);
			#10;
			beat = beat + 8'd1;
		end while (!m_w.last);
		m_wvalid = 1'b0;
		m_bready = 1'b1;
		@(negedge clk);
		while (!m_bvalid) @(negedge clk);
		b = m_b;
		@(posedge clk);
		#10;
		m_bready = 1'b0;
	endtask

	// Collects beats into rbuf until last, optionally stalling rready between beats
	task automatic read_burst(input ax_req_t req, input logic stall);
		logic [4:0] n;
		logic got_last;
		m_ar = req;
		m_arvalid = 1'b1;
		@(negedge clk);
		while (!m_arready) @(negedge clk);
		@(posedge clk);
		#10;
		m_arvalid = 1'b0;
		m_rready = 1'b1;
		n = 5'd0;
		got_last = 1'b0;
		while (!got_last && n < 5'd16) begin
			@(negedge clk);
			while (!m_rvalid) @(negedge clk);
			rbuf[n[3:0]] = m_r;
			got_last = m_r.last;
			n = n + 5'd1;
			@(posedge clk);
			#10;
			if (stall && !got_last) begin
				m_rready = 1'b0;
				repeat (3) begin
					@(negedge clk);
					compare_ready(m_rvalid, 1'b1, "rvalid under back-pressure");
				end
				@(posedge clk);
				#10;
				m_rready = 1'b1;
			end
		end
		m_rready = 1'b0;
		rcount = n;
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		compare_ready(m_awready, 1'b1, "awready after reset");
		compare_ready(m_arready, 1'b1, "arready after reset");
		compare_ready(m_bvalid, 1'b0, "bvalid after reset");
		compare_ready(m_rvalid, 1'b0, "rvalid after reset");
		compare_ready(m_wready, 1'b0, "wready after reset");
		compare_ready(s_awvalid, 1'b0, "slave awvalid after reset");
		compare_ready(s_wvalid, 1'b0, "slave wvalid after reset");
		compare_ready(s_arvalid, 1'b0, "slave arvalid after reset");
		compare_ready(s_bready, 1'b0, "slave bready after reset");
		compare_ready(s_rready, 1'b0, "slave rready after reset");
		@(posedge clk);
		#10;
	endtask

	task automatic test_single_rw();
		b_resp_t b;
		keep_data = $urandom;
		wbuf[0] = keep_data;
		write_burst(make_req(KEEP_ADDR, 4'h3, 8'd0), b);
		compare_b(b, exp_b(4'h3, RESP_OKAY), "single write");
		read_burst(make_req(KEEP_ADDR, 4'h3, 8'd0), 1'b0);
		compare_count(rcount, 5'd1, "single read");
		compare_r(rbuf[0], exp_r(4'h3, keep_data, RESP_OKAY, 1'b1), "single read");
	endtask

	task automatic test_unmapped_write();
		b_resp_t b;
		wbuf[0] = ~keep_data;
		write_burst(make_req(BAD_ADDR, 4'h5, 8'd0), b);
		compare_b(b, exp_b(4'h5, RESP_DECERR), "unmapped write");
		read_burst(make_req(KEEP_ADDR, 4'h6, 8'd0), 1'b0);
		compare_r(rbuf[0], exp_r(4'h6, keep_data, RESP_OKAY, 1'b1), "read after unmapped write");
	endtask

	task automatic test_unmapped_read();
		logic [3:0] i;
		read_burst(make_req(32'h0000_0FFC, 4'h9, 8'd3), 1'b0);
		compare_count(rcount, 5'd4, "unmapped read");
		for (i = 4'd0; i < 4'd4; i++) begin
			compare_r(rbuf[i], exp_r(4'h9, 32'h0, RESP_DECERR, i == 4'd3), "unmapped read");
		end
		@(negedge clk);
		compare_ready(m_rvalid, 1'b0, "rvalid after final beat");
		@(posedge clk);
		#10;
	endtask

	task automatic test_burst();
		b_resp_t b;
		logic [3:0] i;
		for (i = 4'd0; i < 4'd4; i++) begin
			wbuf[i] = $urandom;
		end
		write_burst(make_req(32'h0000_1200, 4'hA, 8'd3), b);
		compare_b(b, exp_b(4'hA, RESP_OKAY), "burst write");
		read_burst(make_req(32'h0000_1200, 4'hA, 8'd3), 1'b1);
		compare_count(rcount, 5'd4, "burst read");
		for (i = 4'd0; i < 4'd4; i++) begin
			compare_r(rbuf[i], exp_r(4'hA, wbuf[i], RESP_OKAY, i == 4'd3), "burst read");
		end
	endtask

	task automatic test_window_edges();
		b_resp_t b;
		wbuf[0] = $urandom;
		write_burst(make_req(32'h0000_1000, 4'h1, 8'd0), b);
		compare_b(b, exp_b(4'h1, RESP_OKAY), "window base write");
		wbuf[0] = $urandom;
		write_burst(make_req(32'h0000_1FFC, 4'h2, 8'd0), b);
		compare_b(b, exp_b(4'h2, RESP_OKAY), "window top write");
		read_burst(make_req(32'h0000_1FFC, 4'h2, 8'd0), 1'b0);
		compare_r(rbuf[0], exp_r(4'h2, wbuf[0], RESP_OKAY, 1'b1), "window top read");
		write_burst(make_req(BAD_ADDR, 4'h4, 8'd0), b);
		compare_b(b, exp_b(4'h4, RESP_DECERR), "past window write");
	endtask

	initial begin
		void'($urandom(70));
		errors = 0;
		checks = 0;
		cycles = 0;
		clk = 1'b0;
		rstn = 1'b0;
		m_aw = '0;
		m_awvalid = 1'b0;
		m_w = '0;
		m_wvalid = 1'b0;
		m_bready = 1'b0;
		m_ar = '0;
		m_arvalid = 1'b0;
		m_rready = 1'b0;
		repeat (3) @(posedge clk);
		#10;
		rstn = 1'b1;

		test_reset_state();
		test_single_rw();
		test_unmapped_write();
		test_unmapped_read();
		test_burst();
		test_window_edges();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_mem_slave.sv
//==============================
// Behavioral AXI4 memory slave
// 256 words, OKAY responses
//==============================
`default_nettype none
`timescale 1ns/100ps

module tb_mem_slave
	import axi_bridge_pkg::*;
(
	input logic clk,
	input logic rstn,
	input ax_req_t aw_i,
	input logic awvalid_i,
	output logic awready_o,
	input w_beat_t w_i,
	input logic wvalid_i,
	output logic wready_o,
	output b_resp_t b_o,
	output logic bvalid_o,
	input logic bready_i,
	input ax_req_t ar_i,
	input logic arvalid_i,
	output logic arready_o,
	output r_beat_t r_o,
	output logic rvalid_o,
	input logic rready_i
);

	logic [DATA_W-1:0] mem [0:255];
	logic [7:0] wptr_q;
	logic [ID_W-1:0] bid_q;
	logic bvalid_q;
	logic [7:0] rptr_q;
	logic [ID_W-1:0] rid_q;
	logic [7:0] rlen_q;
	logic [7:0] rcnt_q;
	logic rbusy_q;

	assign awready_o = 1'b1;
	assign wready_o = 1'b1;
	assign bvalid_o = bvalid_q;
	assign b_o = '{id: bid_q, resp: RESP_OKAY};

	// One read burst is served at a time
	assign arready_o = !rbusy_q;
	assign rvalid_o = rbusy_q;
	assign r_o = '{id: rid_q, data: mem[rptr_q], resp: RESP_OKAY, last: (rcnt_q == rlen_q)};

	// Full-word writes, incrementing bursts
	always_ff @(posedge clk) begin
		if (awvalid_i) begin
			wptr_q <= aw_i.addr[9:2];
			bid_q <= aw_i.id;
		end else if (wvalid_i) begin
			mem[wptr_q] <= w_i.data;
			wptr_q <= wptr_q + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			bvalid_q <= 1'b0;
			rbusy_q <= 1'b0;
		end else begin
			if (wvalid_i && w_i.last) begin
				bvalid_q <= 1'b1;
			end else if (bvalid_q && bready_i) begin
				bvalid_q <= 1'b0;
			end
			if (arvalid_i && !rbusy_q) begin
				rptr_q <= ar_i.addr[9:2];
				rid_q <= ar_i.id;
				rlen_q <= ar_i.len;
				rcnt_q <= 8'd0;
				rbusy_q <= 1'b1;
			end else if (rbusy_q && rready_i) begin
				if (rcnt_q == rlen_q) begin
					rbusy_q <= 1'b0;
				end else begin
					rcnt_q <= rcnt_q + 8'd1;
					rptr_q <= rptr_q + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/axi_bridge_1x1.sv
//==============================
// Single-master AXI4 bridge top
// Write path, read path and
// decode-error target
//==============================
`default_nettype none
`timescale 1ns/100ps

module axi_bridge_1x1
	import axi_bridge_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SLAVE0_BASE = 32'h0000_1000,
	parameter logic [ADDR_W-1:0] SLAVE0_LIMIT = 32'h0000_1FFF
) (
	input logic clk,
	input logic rstn,
	input ax_req_t m_aw_i,
	input logic m_awvalid_i,
	output logic m_awready_o,
	input w_beat_t m_w_i,
	input logic m_wvalid_i,
	output logic m_wready_o,
	output b_resp_t m_b_o,
	output logic m_bvalid_o,
	input logic m_bready_i,
	input ax_req_t m_ar_i,
	input logic m_arvalid_i,
	output logic m_arready_o,
	output r_beat_t m_r_o,
	output logic m_rvalid_o,
	input logic m_rready_i,
	output ax_req_t s_aw_o,
	output logic s_awvalid_o,
	input logic s_awready_i,
	output w_beat_t s_w_o,
	output logic s_wvalid_o,
	input logic s_wready_i,
	input b_resp_t s_b_i,
	input logic s_bvalid_i,
	output logic s_bready_o,
	output ax_req_t s_ar_o,
	output logic s_arvalid_o,
	input logic s_arready_i,
	input r_beat_t s_r_i,
	input logic s_rvalid_i,
	output logic s_rready_o
);

	// Links to the decode-error target
	ax_req_t e_aw;
	logic e_awvalid;
	logic e_awready;
	w_beat_t e_w;
	logic e_wvalid;
	logic e_wready;
	b_resp_t e_b;
	logic e_bvalid;
	logic e_bready;
	ax_req_t e_ar;
	logic e_arvalid;
	logic e_arready;
	r_beat_t e_r;
	logic e_rvalid;
	logic e_rready;

	axi_write_path #(
		.SLAVE0_BASE(SLAVE0_BASE),
		.SLAVE0_LIMIT(SLAVE0_LIMIT)
	) u_write (
		.clk(clk),
		.rstn(rstn),
		.m_aw_i(m_aw_i),
		.m_awvalid_i(m_awvalid_i),
		.m_awready_o(m_awready_o),
		.m_w_i(m_w_i),
		.m_wvalid_i(m_wvalid_i),
		.m_wready_o(m_wready_o),
		.m_b_o(m_b_o),
		.m_bvalid_o(m_bvalid_o),
		.m_bready_i(m_bready_i),
		.s_aw_o(s_aw_o),
		.s_awvalid_o(s_awvalid_o),
		.s_awready_i(s_awready_i),
		.s_w_o(s_w_o),
		.s_wvalid_o(s_wvalid_o),
		.s_wready_i(s_wready_i),
		.s_b_i(s_b_i),
		.s_bvalid_i(s_bvalid_i),
		.s_bready_o(s_bready_o),
		.e_aw_o(e_aw),
		.e_awvalid_o(e_awvalid),
		.e_awready_i(e_awready),
		.e_w_o(e_w),
		.e_wvalid_o(e_wvalid),
		.e_wready_i(e_wready),
		.e_b_i(e_b),
		.e_bvalid_i(e_bvalid),
		.e_bready_o(e_bready)
	);

	axi_read_path #(
		.SLAVE0_BASE(SLAVE0_BASE),
		.SLAVE0_LIMIT(SLAVE0_LIMIT)
	) u_read (
		.clk(clk),
		.rstn(rstn),
		.m_ar_i(m_ar_i),
		.m_arvalid_i(m_arvalid_i),
		.m_arready_o(m_arready_o),
		.m_r_o(m_r_o),
		.m_rvalid_o(m_rvalid_o),
		.m_rready_i(m_rready_i),
		.s_ar_o(s_ar_o),
		.s_arvalid_o(s_arvalid_o),
		.s_arready_i(s_arready_i),
		.s_r_i(s_r_i),
		.s_rvalid_i(s_rvalid_i),
		.s_rready_o(s_rready_o),
		.e_ar_o(e_ar),
		.e_arvalid_o(e_arvalid),
		.e_arready_i(e_arready),
		.e_r_i(e_r),
		.e_rvalid_i(e_rvalid),
		.e_rready_o(e_rready)
	);

	axi_decerr_target u_decerr (
		.clk(clk),
		.rstn(rstn),
		.e_aw_i(e_aw),
		.e_awvalid_i(e_awvalid),
		.e_awready_o(e_awready),
		.e_w_i(e_w),
		.e_wvalid_i(e_wvalid),
		.e_wready_o(e_wready),
		.e_b_o(e_b),
		.e_bvalid_o(e_bvalid),
		.e_bready_i(e_bready),
		.e_ar_i(e_ar),
		.e_arvalid_i(e_arvalid),
		.e_arready_o(e_arready),
		.e_r_o(e_r),
		.e_rvalid_o(e_rvalid),
		.e_rready_i(e_rready)
	);

endmodule

`default_nettype wire

// File: verilog/axi_bridge_pkg.sv
//==============================
// Shared AXI4 bridge definitions
// Bus widths and channel payload structs
// Response, target and FSM state enums
// Address window match function
//==============================
`default_nettype none

package axi_bridge_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W = 4;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	typedef enum logic {
		TGT_SLAVE0 = 1'b0,
		TGT_DECERR = 1'b1
	} target_e;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_DECODE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_DECODE,
		RD_ADDR
	} rd_state_e;

	// AW and AR share one payload layout
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [3:0] cache;
		logic [2:0] prot;
	} ax_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic last;
	} w_beat_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		resp_e resp;
	} b_resp_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [DATA_W-1:0] data;
		resp_e resp;
		logic last;
	} r_beat_t;

	// Both window ends are inclusive
	function automatic logic in_window(
		input logic [ADDR_W-1:0] addr,
		input logic [ADDR_W-1:0] base,
		input logic [ADDR_W-1:0] limit
	);
		return (addr >= base) && (addr <= limit);
	endfunction

endpackage

`default_nettype wire

// File: verilog/axi_decerr_target.sv
//==============================
// Decode-error target
// Sinks unmapped writes and answers DECERR
// Returns zero beats with DECERR for reads
//==============================
`default_nettype none
`timescale 1ns/100ps

module axi_decerr_target
	import axi_bridge_pkg::*;
(
	input logic clk,
	input logic rstn,
	input ax_req_t e_aw_i,
	input logic e_awvalid_i,
	output logic e_awready_o,
	input w_beat_t e_w_i,
	input logic e_wvalid_i,
	output logic e_wready_o,
	output b_resp_t e_b_o,
	output logic e_bvalid_o,
	input logic e_bready_i,
	input ax_req_t e_ar_i,
	input logic e_arvalid_i,
	output logic e_arready_o,
	output r_beat_t e_r_o,
	output logic e_rvalid_o,
	input logic e_rready_i
);

	typedef enum logic [1:0] {
		DW_IDLE,
		DW_DATA,
		DW_RESP
	} dw_state_e;

	typedef enum logic {
		DR_IDLE,
		DR_BEATS
	} dr_state_e;

	dw_state_e wr_state;
	dr_state_e rd_state;
	logic [ID_W-1:0] wid_q;
	logic [ID_W-1:0] rid_q;
	logic [7:0] len_q;
	logic [7:0] cnt_q;

	assign e_awready_o = (wr_state == DW_IDLE);
	assign e_wready_o = (wr_state == DW_DATA);
	assign e_bvalid_o = (wr_state == DW_RESP);
	assign e_b_o = '{id: wid_q, resp: RESP_DECERR};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_state <= DW_IDLE;
		end else begin
			case (wr_state)
				DW_IDLE: begin
					if (e_awvalid_i) begin
						wid_q <= e_aw_i.id;
						wr_state <= DW_DATA;
					end
				end
				DW_DATA: begin
					// Data is dropped and only the end of the burst matters
					if (e_wvalid_i && e_w_i.last) begin
						wr_state <= DW_RESP;
					end
				end
				DW_RESP: begin
					if (e_bready_i) begin
						wr_state <= DW_IDLE;
					end
				end
				default: wr_state <= DW_IDLE;
			endcase
		end
	end

	assign e_arready_o = (rd_state == DR_IDLE);
	assign e_rvalid_o = (rd_state == DR_BEATS);
	assign e_r_o = '{id: rid_q, data: '0, resp: RESP_DECERR,
		last: (rd_state == DR_BEATS) && (cnt_q == len_q)};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_state <= DR_IDLE;
			cnt_q <= '0;
		end else if (rd_state == DR_IDLE) begin
			if (e_arvalid_i) begin
				rid_q <= e_ar_i.id;
				len_q <= e_ar_i.len;
				cnt_q <= '0;
				rd_state <= DR_BEATS;
			end
		end else if (e_rready_i) begin
			if (e_r_o.last) begin
				rd_state <= DR_IDLE;
			end else begin
				cnt_q <= cnt_q + 8'd1;
			end
		end
	end

	// A waiting read request is held steady until this target takes it
	assert property (@(posedge clk) disable iff (!rstn)
		(e_arvalid_i && !e_arready_o) |=> (e_arvalid_i && $stable(e_ar_i)));

	// Write beats only arrive for an accepted address with no response pending
	assert property (@(posedge clk) disable iff (!rstn)
		e_wvalid_i |-> (wr_state == DW_DATA));

endmodule

`default_nettype wire

// File: verilog/axi_read_path.sv
//==============================
// AXI4 read path
// AR capture, decode and forwarding
// R beat lock and selection between targets
//==============================
`default_nettype none
`timescale 1ns/100ps

module axi_read_path
	import axi_bridge_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SLAVE0_BASE = 32'h0000_1000,
	parameter logic [ADDR_W-1:0] SLAVE0_LIMIT = 32'h0000_1FFF
) (
	input logic clk,
	input logic rstn,
	// Master side
	input ax_req_t m_ar_i,
	input logic m_arvalid_i,
	output logic m_arready_o,
	output r_beat_t m_r_o,
	output logic m_rvalid_o,
	input logic m_rready_i,
	// Slave port
	output ax_req_t s_ar_o,
	output logic s_arvalid_o,
	input logic s_arready_i,
	input r_beat_t s_r_i,
	input logic s_rvalid_i,
	output logic s_rready_o,
	// Decode-error target
	output ax_req_t e_ar_o,
	output logic e_arvalid_o,
	input logic e_arready_i,
	input r_beat_t e_r_i,
	input logic e_rvalid_i,
	output logic e_rready_o
);

	rd_state_e state;
	target_e tgt_q;
	ax_req_t ar_q;
	logic tgt_slv;
	logic lock_vld_q;
	target_e lock_tgt_q;
	target_e r_tgt;
	logic r_last_hs;

	assign tgt_slv = (tgt_q == TGT_SLAVE0);
	assign m_arready_o = (state == RD_IDLE);

	// Request side frees up once the target takes the address
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= RD_IDLE;
			tgt_q <= TGT_SLAVE0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (m_arvalid_i) begin
						state <= RD_DECODE;
					end
				end
				RD_DECODE: begin
					tgt_q <= in_window(ar_q.addr, SLAVE0_BASE, SLAVE0_LIMIT) ?
						TGT_SLAVE0 : TGT_DECERR;
					state <= RD_ADDR;
				end
				RD_ADDR: begin
					if (tgt_slv ? s_arready_i : e_arready_i) begin
						state <= RD_IDLE;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (m_arvalid_i && m_arready_o) begin
			ar_q <= m_ar_i;
		end
	end

	assign s_ar_o = ar_q;
	assign e_ar_o = ar_q;
	assign s_arvalid_o = (state == RD_ADDR) && tgt_slv;
	assign e_arvalid_o = (state == RD_ADDR) && !tgt_slv;

	// Free lock picks the slave first, then the error target
	assign r_tgt = lock_vld_q ? lock_tgt_q : (s_rvalid_i ? TGT_SLAVE0 : TGT_DECERR);

	assign m_r_o = (r_tgt == TGT_SLAVE0) ? s_r_i : e_r_i;
	assign m_rvalid_o = (r_tgt == TGT_SLAVE0) ? s_rvalid_i : e_rvalid_i;
	assign s_rready_o = (r_tgt == TGT_SLAVE0) && m_rready_i;
	assign e_rready_o = (r_tgt == TGT_DECERR) && m_rready_i;
	assign r_last_hs = m_rvalid_o && m_rready_i && m_r_o.last;

	// Hold the burst source until its last beat is taken
	always_ff @(posedge clk) begin
		if (!rstn) begin
			lock_vld_q <= 1'b0;
			lock_tgt_q <= TGT_SLAVE0;
		end else if (m_rvalid_o) begin
			if (r_last_hs) begin
				lock_vld_q <= 1'b0;
			end else begin
				lock_vld_q <= 1'b1;
				lock_tgt_q <= r_tgt;
			end
		end
	end

	// A stalled beat stays on the master port until it is taken
	assert property (@(posedge clk) disable iff (!rstn)
		(m_rvalid_o && !m_rready_i) |=> (m_rvalid_o && $stable(m_r_o)));

endmodule

`default_nettype wire

// File: verilog/axi_write_path.sv
//==============================
// AXI4 write path
// AW capture and decode, AW forwarding,
// W steering and B return, one write at a time
//==============================
`default_nettype none
`timescale 1ns/100ps

module axi_write_path
	import axi_bridge_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SLAVE0_BASE = 32'h0000_1000,
	parameter logic [ADDR_W-1:0] SLAVE0_LIMIT = 32'h0000_1FFF
) (
	input logic clk,
	input logic rstn,
	// Master side
	input ax_req_t m_aw_i,
	input logic m_awvalid_i,
	output logic m_awready_o,
	input w_beat_t m_w_i,
	input logic m_wvalid_i,
	output logic m_wready_o,
	output b_resp_t m_b_o,
	output logic m_bvalid_o,
	input logic m_bready_i,
	// Slave port
	output ax_req_t s_aw_o,
	output logic s_awvalid_o,
	input logic s_awready_i,
	output w_beat_t s_w_o,
	output logic s_wvalid_o,
	input logic s_wready_i,
	input b_resp_t s_b_i,
	input logic s_bvalid_i,
	output logic s_bready_o,
	// Decode-error target
	output ax_req_t e_aw_o,
	output logic e_awvalid_o,
	input logic e_awready_i,
	output w_beat_t e_w_o,
	output logic e_wvalid_o,
	input logic e_wready_i,
	input b_resp_t e_b_i,
	input logic e_bvalid_i,
	output logic e_bready_o
);

	wr_state_e state;
	target_e tgt_q;
	ax_req_t aw_q;
	logic tgt_slv;
	logic aw_fwd_ready;

	assign tgt_slv = (tgt_q == TGT_SLAVE0);
	assign aw_fwd_ready = tgt_slv ? s_awready_i : e_awready_i;

	assign m_awready_o = (state == WR_IDLE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= WR_IDLE;
			tgt_q <= TGT_SLAVE0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (m_awvalid_i) begin
						state <= WR_DECODE;
					end
				end
				WR_DECODE: begin
					tgt_q <= in_window(aw_q.addr, SLAVE0_BASE, SLAVE0_LIMIT) ?
						TGT_SLAVE0 : TGT_DECERR;
					state <= WR_ADDR;
				end
				WR_ADDR: begin
					if (aw_fwd_ready) begin
						state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (m_wvalid_i && m_wready_o && m_w_i.last) begin
						state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (m_bvalid_o && m_bready_i) begin
						state <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (m_awvalid_i && m_awready_o) begin
			aw_q <= m_aw_i;
		end
	end

	// Registered request goes to whichever target was decoded
	assign s_aw_o = aw_q;
	assign e_aw_o = aw_q;
	assign s_awvalid_o = (state == WR_ADDR) && tgt_slv;
	assign e_awvalid_o = (state == WR_ADDR) && !tgt_slv;

	// Data beats pass straight through to the chosen target
	assign s_w_o = m_w_i;
	assign e_w_o = m_w_i;
	assign s_wvalid_o = (state == WR_DATA) && tgt_slv && m_wvalid_i;
	assign e_wvalid_o = (state == WR_DATA) && !tgt_slv && m_wvalid_i;
	assign m_wready_o = (state == WR_DATA) && (tgt_slv ? s_wready_i : e_wready_i);

	assign m_b_o = tgt_slv ? s_b_i : e_b_i;
	assign m_bvalid_o = (state == WR_RESP) && (tgt_slv ? s_bvalid_i : e_bvalid_i);
	assign s_bready_o = (state == WR_RESP) && tgt_slv && m_bready_i;
	assign e_bready_o = (state == WR_RESP) && !tgt_slv && m_bready_i;

	// Write data only reaches the target that the held address decodes to
	assert property (@(posedge clk) disable iff (!rstn)
		s_wvalid_o |-> in_window(aw_q.addr, SLAVE0_BASE, SLAVE0_LIMIT));

	assert property (@(posedge clk) disable iff (!rstn)
		e_wvalid_o |-> !in_window(aw_q.addr, SLAVE0_BASE, SLAVE0_LIMIT));

endmodule

`default_nettype wire
